//--- noc_rr_params.svh
// mesh router arbitration parameters

`ifndef NOC_RR_PARAMS_SVH
`define NOC_RR_PARAMS_SVH

// router port count
`define NOC_PORTS 5

// inputs competing for one output, all ports except the own one
`define NOC_CANDS 4

// next-hop code width
`define NOC_ADDR_W 3

// next-hop direction codes
`define NOC_DIR_N 3'd0
`define NOC_DIR_S 3'd1
`define NOC_DIR_W 3'd2
`define NOC_DIR_E 3'd3
`define NOC_DIR_L 3'd4

// no packet waiting on this input
`define NOC_DIR_NONE 3'd7

`endif

//--- noc_rr_pkg.sv
// mesh router arbitration types

`include "noc_rr_params.svh"

package noc_rr_pkg;

  // next-hop direction code of one input
  typedef logic [`NOC_ADDR_W-1:0] nexthop_t;

  // one bit per router port
  // bit 4 is north, then south, west, east, local at bit 0
  typedef logic [`NOC_PORTS-1:0] port_vec_t;

  // one bit per competing input inside a processor
  typedef logic [`NOC_CANDS-1:0] cand_vec_t;

  // slot position in the round-robin order
  typedef logic [$clog2(`NOC_CANDS)-1:0] cand_idx_t;

endpackage

//--- rr_comparator.sv
// next-hop request comparator

`timescale 1ns/1ns

`include "noc_rr_params.svh"

module rr_comparator #(
  parameter int OUT_DIR = `NOC_DIR_N
) (
  input  noc_rr_pkg::nexthop_t  cand0_nexthop_i,
  input  noc_rr_pkg::nexthop_t  cand1_nexthop_i,
  input  noc_rr_pkg::nexthop_t  cand2_nexthop_i,
  input  noc_rr_pkg::nexthop_t  cand3_nexthop_i,
  output noc_rr_pkg::cand_vec_t req_o
);

  // code an input must carry to ask for this output
  localparam noc_rr_pkg::nexthop_t OWN_CODE = noc_rr_pkg::nexthop_t'(OUT_DIR);

  // slot i requests when its next hop is this output
  // NONE is 7 and never equals a real direction
  always_comb begin
    req_o[0] = (cand0_nexthop_i == OWN_CODE);
    req_o[1] = (cand1_nexthop_i == OWN_CODE);
    req_o[2] = (cand2_nexthop_i == OWN_CODE);
    req_o[3] = (cand3_nexthop_i == OWN_CODE);
  end

endmodule

//--- rr_priority_register.sv
// round-robin order pointer

`timescale 1ns/1ns

module rr_priority_register (
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic                  change_order_i,
  output noc_rr_pkg::cand_idx_t order_ptr_o
);

  noc_rr_pkg::cand_idx_t order_ptr;

  // starting slot of the priority scan
  // the 2-bit counter wraps from 3 back to 0 by itself
  always_ff @(posedge clk) begin
    if (rst_i) begin
      order_ptr <= '0;
    end else if (change_order_i) begin
      order_ptr <= order_ptr + noc_rr_pkg::cand_idx_t'(1);
    end
  end

  assign order_ptr_o = order_ptr;

  // pointer holds when no strobe arrives
  a_ptr_hold: assert property (
    @(posedge clk) disable iff (rst_i)
    !change_order_i |=> $stable(order_ptr_o)
  );

endmodule

//--- rr_grant_encoder.sv
// rotated priority grant encoder

`timescale 1ns/1ns

`include "noc_rr_params.svh"

module rr_grant_encoder #(
  parameter int OUT_DIR = `NOC_DIR_N
) (
  input  logic                  clk,
  input  noc_rr_pkg::cand_vec_t req_i,
  input  noc_rr_pkg::cand_idx_t order_ptr_i,
  output noc_rr_pkg::port_vec_t grant_o,
  output logic                  to_cs_o
);

  // grant bit of this output's own port, never set
  localparam int OWN_BIT = `NOC_PORTS - 1 - OUT_DIR;

  logic [2*`NOC_CANDS-1:0] req_dbl;
  noc_rr_pkg::cand_vec_t   rot_req;
  noc_rr_pkg::cand_idx_t   win_off;
  noc_rr_pkg::cand_idx_t   win_slot;
  logic                    win_found;
  noc_rr_pkg::cand_vec_t   cand_grant;

  // rotate requests so the pointer slot lands at offset 0
  assign req_dbl = {req_i, req_i};
  assign rot_req = req_dbl[order_ptr_i +: `NOC_CANDS];

  // lowest requesting offset wins
  always_comb begin
    win_found = 1'b0;
    win_off   = '0;
    for (int k = `NOC_CANDS - 1; k >= 0; k--) begin
      if (rot_req[k]) begin
        win_found = 1'b1;
        win_off   = noc_rr_pkg::cand_idx_t'(k);
      end
    end
  end

  // back to the unrotated slot, modulo 4
  assign win_slot   = order_ptr_i + win_off;
  assign cand_grant = win_found ? (noc_rr_pkg::cand_vec_t'(1) << win_slot) : '0;
  assign to_cs_o    = win_found;

  // slots skip the own direction, so slots at or past it shift up one port
  for (genvar i = 0; i < `NOC_CANDS; i++) begin : g_slot_map
    localparam int SLOT_DIR = (i < OUT_DIR) ? i : i + 1;
    assign grant_o[`NOC_PORTS-1-SLOT_DIR] = cand_grant[i];
  end

  assign grant_o[OWN_BIT] = 1'b0;

  a_grant_onehot: assert property (
    @(posedge clk) $onehot0(grant_o)
  );

  a_to_cs_match: assert property (
    @(posedge clk) to_cs_o == (grant_o != '0)
  );

  // no U-turn back into the own port
  a_no_uturn: assert property (
    @(posedge clk) !grant_o[OWN_BIT]
  );

endmodule

//--- rr_processor.sv
// output port round-robin processor

`timescale 1ns/1ns

`include "noc_rr_params.svh"

module rr_processor #(
  parameter int OUT_DIR = `NOC_DIR_N
) (
  input  logic                  clk,
  input  logic                  rst_i,
  input  noc_rr_pkg::nexthop_t  cand0_nexthop_i,
  input  noc_rr_pkg::nexthop_t  cand1_nexthop_i,
  input  noc_rr_pkg::nexthop_t  cand2_nexthop_i,
  input  noc_rr_pkg::nexthop_t  cand3_nexthop_i,
  input  logic                  change_order_i,
  output noc_rr_pkg::port_vec_t grant_o,
  output logic                  to_cs_o
);

  noc_rr_pkg::cand_vec_t req;
  noc_rr_pkg::cand_idx_t order_ptr;

  // which of the four other inputs want this output
  rr_comparator #(
    .OUT_DIR (OUT_DIR)
  ) rr_comparator_inst (
    .cand0_nexthop_i (cand0_nexthop_i),
    .cand1_nexthop_i (cand1_nexthop_i),
    .cand2_nexthop_i (cand2_nexthop_i),
    .cand3_nexthop_i (cand3_nexthop_i),
    .req_o           (req)
  );

  // rotating start slot
  rr_priority_register rr_priority_register_inst (
    .clk            (clk),
    .rst_i          (rst_i),
    .change_order_i (change_order_i),
    .order_ptr_o    (order_ptr)
  );

  // winner and crossbar valid
  rr_grant_encoder #(
    .OUT_DIR (OUT_DIR)
  ) rr_grant_encoder_inst (
    .clk         (clk),
    .req_i       (req),
    .order_ptr_i (order_ptr),
    .grant_o     (grant_o),
    .to_cs_o     (to_cs_o)
  );

  // without a strobe and with unchanged next hops the grant must not move
  a_grant_held: assert property (
    @(posedge clk) disable iff (rst_i)
    (!change_order_i ##1
      $stable({cand0_nexthop_i, cand1_nexthop_i, cand2_nexthop_i, cand3_nexthop_i}))
    |-> $stable(grant_o)
  );

  // a strobe with one lone requester leaves that requester granted
  a_single_req: assert property (
    @(posedge clk) disable iff (rst_i)
    ($onehot(req) ##1 $stable(req)) |-> $stable(grant_o)
  );

endmodule

//--- rr_arbiter_top.sv
// five port router switch arbiter

`timescale 1ns/1ns

`include "noc_rr_params.svh"

module rr_arbiter_top (
  input  logic                  clk,
  input  logic                  rst_i,
  input  noc_rr_pkg::nexthop_t  n_nexthop_i,
  input  noc_rr_pkg::nexthop_t  s_nexthop_i,
  input  noc_rr_pkg::nexthop_t  w_nexthop_i,
  input  noc_rr_pkg::nexthop_t  e_nexthop_i,
  input  noc_rr_pkg::nexthop_t  l_nexthop_i,
  input  noc_rr_pkg::port_vec_t change_order_i,
  output noc_rr_pkg::port_vec_t n_grant_o,
  output logic                  n_to_cs_o,
  output noc_rr_pkg::port_vec_t s_grant_o,
  output logic                  s_to_cs_o,
  output noc_rr_pkg::port_vec_t w_grant_o,
  output logic                  w_to_cs_o,
  output noc_rr_pkg::port_vec_t e_grant_o,
  output logic                  e_to_cs_o,
  output noc_rr_pkg::port_vec_t l_grant_o,
  output logic                  l_to_cs_o
);

  // north output, candidates S W E L
  rr_processor #(.OUT_DIR(`NOC_DIR_N)) rr_processor_n_inst (
    .clk             (clk),
    .rst_i           (rst_i),
    .cand0_nexthop_i (s_nexthop_i),
    .cand1_nexthop_i (w_nexthop_i),
    .cand2_nexthop_i (e_nexthop_i),
    .cand3_nexthop_i (l_nexthop_i),
    .change_order_i  (change_order_i[`NOC_PORTS-1-`NOC_DIR_N]),
    .grant_o         (n_grant_o),
    .to_cs_o         (n_to_cs_o)
  );

  // south output, candidates N W E L
  rr_processor #(.OUT_DIR(`NOC_DIR_S)) rr_processor_s_inst (
    .clk             (clk),
    .rst_i           (rst_i),
    .cand0_nexthop_i (n_nexthop_i),
    .cand1_nexthop_i (w_nexthop_i),
    .cand2_nexthop_i (e_nexthop_i),
    .cand3_nexthop_i (l_nexthop_i),
    .change_order_i  (change_order_i[`NOC_PORTS-1-`NOC_DIR_S]),
    .grant_o         (s_grant_o),
    .to_cs_o         (s_to_cs_o)
  );

  // west output, candidates N S E L
  rr_processor #(.OUT_DIR(`NOC_DIR_W)) rr_processor_w_inst (
    .clk             (clk),
    .rst_i           (rst_i),
    .cand0_nexthop_i (n_nexthop_i),
    .cand1_nexthop_i (s_nexthop_i),
    .cand2_nexthop_i (e_nexthop_i),
    .cand3_nexthop_i (l_nexthop_i),
    .change_order_i  (change_order_i[`NOC_PORTS-1-`NOC_DIR_W]),
    .grant_o         (w_grant_o),
    .to_cs_o         (w_to_cs_o)
  );

  // east output, candidates N S W L
  rr_processor #(.OUT_DIR(`NOC_DIR_E)) rr_processor_e_inst (
    .clk             (clk),
    .rst_i           (rst_i),
    .cand0_nexthop_i (n_nexthop_i),
    .cand1_nexthop_i (s_nexthop_i),
    .cand2_nexthop_i (w_nexthop_i),
    .cand3_nexthop_i (l_nexthop_i),
    .change_order_i  (change_order_i[`NOC_PORTS-1-`NOC_DIR_E]),
    .grant_o         (e_grant_o),
    .to_cs_o         (e_to_cs_o)
  );

  // local output, candidates N S W E
  rr_processor #(.OUT_DIR(`NOC_DIR_L)) rr_processor_l_inst (
    .clk             (clk),
    .rst_i           (rst_i),
    .cand0_nexthop_i (n_nexthop_i),
    .cand1_nexthop_i (s_nexthop_i),
    .cand2_nexthop_i (w_nexthop_i),
    .cand3_nexthop_i (e_nexthop_i),
    .change_order_i  (change_order_i[`NOC_PORTS-1-`NOC_DIR_L]),
    .grant_o         (l_grant_o),
    .to_cs_o         (l_to_cs_o)
  );

endmodule

//--- tb_rr_arbiter.sv
// router switch arbiter testbench

`timescale 1ns/1ns

`include "noc_rr_params.svh"

module tb_rr_arbiter;

  localparam int MAX_CYCLES = 20000;

  logic                  clk;
  logic                  rst_i;
  noc_rr_pkg::nexthop_t  nh [`NOC_PORTS];
  noc_rr_pkg::port_vec_t change_order;
  noc_rr_pkg::port_vec_t grant [`NOC_PORTS];
  logic                  to_cs [`NOC_PORTS];

  // values for the next edge and the model's pointers
  noc_rr_pkg::nexthop_t  drv_nh [`NOC_PORTS];
  noc_rr_pkg::port_vec_t drv_st;
  int                    ptr [`NOC_PORTS];

  rr_arbiter_top rr_arbiter_top_inst (
    .clk            (clk),
    .rst_i          (rst_i),
    .n_nexthop_i    (nh[0]),
    .s_nexthop_i    (nh[1]),
    .w_nexthop_i    (nh[2]),
    .e_nexthop_i    (nh[3]),
    .l_nexthop_i    (nh[4]),
    .change_order_i (change_order),
    .n_grant_o      (grant[0]),
    .n_to_cs_o      (to_cs[0]),
    .s_grant_o      (grant[1]),
    .s_to_cs_o      (to_cs[1]),
    .w_grant_o      (grant[2]),
    .w_to_cs_o      (to_cs[2]),
    .e_grant_o      (grant[3]),
    .e_to_cs_o      (to_cs[3]),
    .l_grant_o      (grant[4]),
    .l_to_cs_o      (to_cs[4])
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // hard limit on run length
  initial begin
    repeat (MAX_CYCLES) @(posedge clk);
    $display("timeout: the run went past its cycle limit");
    $display("TEST RESULT: FAIL");
    $fatal(1, "cycle limit reached");
  end

  task automatic check_value(input int got, input int exp, input string what);
    if (got !== exp) begin
      $display("ERR @ %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // port number of candidate slot s for output d with the own port skipped
  function automatic int cand_port(input int d, input int s);
    return (s < d) ? s : s + 1;
  endfunction

  // first requesting slot from the pointer as a port bit
  function automatic noc_rr_pkg::port_vec_t model_grant(input int d);
    noc_rr_pkg::port_vec_t g;
    int s;
    int p;
    g = '0;
    for (int k = 0; k < `NOC_CANDS; k++) begin
      s = (ptr[d] + k) % `NOC_CANDS;
      p = cand_port(d, s);
      if (g == '0 && nh[p] == noc_rr_pkg::nexthop_t'(d)) begin
        g[`NOC_PORTS-1-p] = 1'b1;
      end
    end
    return g;
  endfunction

  // slot that holds output d's grant or -1 when idle
  function automatic int grant_slot(input int d);
    int slot;
    slot = -1;
    for (int s = 0; s < `NOC_CANDS; s++) begin
      if (grant[d][`NOC_PORTS-1-cand_port(d, s)]) begin
        slot = s;
      end
    end
    return slot;
  endfunction

  function automatic noc_rr_pkg::nexthop_t rand_code();
    int r;
    r = int'($urandom_range(7, 0));
    // three in eight inputs carry no packet
    return (r > 4) ? `NOC_DIR_NONE : noc_rr_pkg::nexthop_t'(r);
  endfunction

  task automatic check_outputs();
    noc_rr_pkg::port_vec_t g;
    int any_req;
    for (int d = 0; d < `NOC_PORTS; d++) begin
      g = grant[d];
      any_req = 0;
      for (int p = 0; p < `NOC_PORTS; p++) begin
        if (p != d && nh[p] == noc_rr_pkg::nexthop_t'(d)) begin
          any_req = 1;
        end
      end
      check_value(int'(to_cs[d]), any_req, $sformatf("to_cs of output %0d", d));
      check_value(int'(g[`NOC_PORTS-1-d]), 0, $sformatf("u-turn grant on output %0d", d));
      check_value(int'($onehot0(g)), 1, $sformatf("grant of output %0d not one-hot", d));
      check_value(int'(g), int'(model_grant(d)), $sformatf("grant of output %0d", d));
    end
  endtask

  // model follows the edge and new inputs go out, outputs checked mid-cycle
  task automatic run_cycle();
    @(posedge clk);
    for (int d = 0; d < `NOC_PORTS; d++) begin
      if (rst_i) begin
        ptr[d] = 0;
      end else if (change_order[`NOC_PORTS-1-d]) begin
        ptr[d] = (ptr[d] + 1) % `NOC_CANDS;
      end
    end
    for (int p = 0; p < `NOC_PORTS; p++) begin
      nh[p] <= drv_nh[p];
    end
    change_order <= drv_st;
    @(negedge clk);
    if (!rst_i) begin
      check_outputs();
    end
  endtask

  task automatic set_idle();
    for (int p = 0; p < `NOC_PORTS; p++) begin
      drv_nh[p] = `NOC_DIR_NONE;
    end
    drv_st = '0;
  endtask

  // all four candidates of output d ask for it
  task automatic aim_all_at(input int d);
    for (int p = 0; p < `NOC_PORTS; p++) begin
      drv_nh[p] = (p == d) ? rand_code() : noc_rr_pkg::nexthop_t'(d);
    end
  endtask

  task automatic apply_reset();
    set_idle();
    @(posedge clk);
    rst_i <= 1'b1;
    repeat (9) run_cycle();
    @(posedge clk);
    rst_i <= 1'b0;
    for (int d = 0; d < `NOC_PORTS; d++) begin
      ptr[d] = 0;
    end
    @(negedge clk);
  endtask

  // idle outputs after reset and then each pointer shown at slot 0
  task automatic check_after_reset();
    set_idle();
    run_cycle();
    for (int d = 0; d < `NOC_PORTS; d++) begin
      check_value(int'(grant[d]), 0, $sformatf("idle grant of output %0d", d));
      check_value(int'(to_cs[d]), 0, $sformatf("idle to_cs of output %0d", d));
    end
    for (int d = 0; d < `NOC_PORTS; d++) begin
      aim_all_at(d);
      run_cycle();
      check_value(grant_slot(d), 0, $sformatf("first slot after reset, output %0d", d));
    end
  endtask

  initial begin
    noc_rr_pkg::port_vec_t held [`NOC_PORTS];
    int counts [`NOC_CANDS];
    int d;
    int prev;
    int tries;
    void'($urandom(32'h15771bbe));
    rst_i        = 1'b1;
    change_order = '0;
    for (int p = 0; p < `NOC_PORTS; p++) begin
      nh[p]  = `NOC_DIR_NONE;
      ptr[p] = 0;
    end
    set_idle();
    apply_reset();
    check_after_reset();

    // random codes and strobes against the model
    repeat (3000) begin
      for (int p = 0; p < `NOC_PORTS; p++) begin
        drv_nh[p] = rand_code();
        drv_st[p] = ($urandom_range(2, 0) == 0);
      end
      run_cycle();
    end

    // strobes on one output step its grant one slot on
    repeat (20) begin
      d = int'($urandom_range(4, 0));
      aim_all_at(d);
      drv_st = '0;
      run_cycle();
      tries = 0;
      while (grant_slot(d) != 0) begin
        if (tries == 8) begin
          $display("timeout: grant of output %0d never came back to slot 0", d);
          $display("TEST RESULT: FAIL");
          $fatal(1, "rotation wait timed out");
        end
        drv_st = '0;
        drv_st[`NOC_PORTS-1-d] = 1'b1;
        run_cycle();
        drv_st = '0;
        run_cycle();
        tries++;
      end
      repeat (6) begin
        prev = grant_slot(d);
        for (int o = 0; o < `NOC_PORTS; o++) begin
          held[o] = grant[o];
        end
        drv_st = '0;
        drv_st[`NOC_PORTS-1-d] = 1'b1;
        run_cycle();
        drv_st = '0;
        run_cycle();
        check_value(grant_slot(d), (prev + 1) % `NOC_CANDS, "slot after strobe");
        for (int o = 0; o < `NOC_PORTS; o++) begin
          if (o != d) begin
            check_value(int'(grant[o]), int'(held[o]), $sformatf("unstrobed output %0d", o));
          end
        end
      end
    end

    // fairness with one output fully loaded and strobed every cycle
    d = int'($urandom_range(4, 0));
    for (int s = 0; s < `NOC_CANDS; s++) begin
      counts[s] = 0;
    end
    repeat (2000) begin
      aim_all_at(d);
      for (int p = 0; p < `NOC_PORTS; p++) begin
        drv_st[p] = ($urandom_range(2, 0) == 0);
      end
      drv_st[`NOC_PORTS-1-d] = 1'b1;
      run_cycle();
      check_value(int'(grant_slot(d) >= 0), 1, "loaded output granted");
      counts[grant_slot(d)]++;
    end
    for (int s = 0; s < `NOC_CANDS; s++) begin
      check_value(counts[s], 500, $sformatf("grants to slot %0d of output %0d", s, d));
    end

    // mid-run reset
    apply_reset();
    check_after_reset();

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- all.f
+incdir+.
noc_rr_pkg.sv
rr_comparator.sv
rr_priority_register.sv
rr_grant_encoder.sv
rr_processor.sv
rr_arbiter_top.sv
tb_rr_arbiter.sv

//--- run.sh
#!/bin/sh
# build and run the router arbiter testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f all.f \
  --top-module tb_rr_arbiter \
  -o tb_rr_arbiter_sim

# a failing check ends in $fatal, which gives a non-zero exit status
./obj_dir/tb_rr_arbiter_sim
